//--- flist.f
hdl/proxy_pkg.sv
hdl/proxy_cmd_decode.sv
hdl/proxy_reg_blk.sv
hdl/proxy_mem_exec.sv
hdl/proxy_resp_gen.sv
hdl/proxy_test.sv
verif/proxy_test_checker.sv
verif/proxy_test_properties.sv
verif/proxy_test_tb.sv

//--- verif/proxy_test_tb.sv
`timescale 1ns/1ps

module proxy_test_tb;
    import proxy_pkg::*;

    logic        clk;
    logic        srst;
    logic        i_req;
    proxy_req_t  i_req_data;
    logic        o_ack;
    proxy_resp_t o_resp;
    proxy_resp_t exp_resp;
    int          checks;
    int          chk_errors;
    int          cycle_cnt;
    int          cycle_limit;
    proxy_req_t  req_tbl[$];
    proxy_resp_t exp_tbl[$];

    proxy_test DUT (
        .clk,
        .srst,
        .i_req,
        .i_req_data,
        .o_ack,
        .o_resp
    );

    proxy_test_checker checker_inst (
        .clk,
        .srst,
        .i_req,
        .i_ack    ( o_ack ),
        .i_resp   ( o_resp ),
        .i_exp    ( exp_resp ),
        .o_checks ( checks ),
        .o_errors ( chk_errors )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus table helpers
    // --------------------------------------------------
    function automatic proxy_req_t reg_req(logic wr, logic [5:0] addr, logic [31:0] wdata);
        proxy_req_t r;
        r                = '0;
        r.space          = SPACE_REG;
        r.wr             = wr;
        r.op.reg_op.addr = addr;
        r.wdata          = wdata;
        return r;
    endfunction

    function automatic proxy_req_t mem_req(logic wr, logic [3:0] be, logic [9:0] addr,
                                           logic [31:0] wdata);
        proxy_req_t r;
        r                   = '0;
        r.space             = SPACE_MEM;
        r.wr                = wr;
        r.op.mem_op.byte_en = be;
        r.op.mem_op.addr    = addr;
        r.wdata             = wdata;
        return r;
    endfunction

    task automatic add_entry(input proxy_req_t req, input proxy_resp_t exp);
        req_tbl.push_back(req);
        exp_tbl.push_back(exp);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] scr;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] m1;
        logic [31:0] m2;
        logic [31:0] m3;
        logic [31:0] m4;
        logic [31:0] merged;
        int          total_errors;
        void'($urandom(67));
        scr = $urandom();
        t1  = $urandom();
        t2  = $urandom();
        m1  = $urandom();
        m2  = $urandom();
        m3  = $urandom();
        m4  = $urandom();
        // Byte enable 0101 takes bytes 0 and 2 from m3
        merged = {m1[31:24], m3[23:16], m1[15:8], m3[7:0]};

        add_entry(reg_req(1'b0, 6'd0, '0), {1'b0, 32'h2050_5245});
        add_entry(reg_req(1'b0, 6'd1, '0), {1'b0, 32'h504F_5354});
        add_entry(reg_req(1'b1, 6'd4, scr), {1'b0, 32'h0});
        add_entry(reg_req(1'b0, 6'd4, '0), {1'b0, scr});
        add_entry(reg_req(1'b1, 6'd2, t1), {1'b0, 32'h0});
        add_entry(reg_req(1'b0, 6'd3, '0), {1'b0, 16'd1, t1[15:0]});
        add_entry(reg_req(1'b1, 6'd2, t2), {1'b0, 32'h0});
        add_entry(reg_req(1'b0, 6'd3, '0), {1'b0, 16'd2, t2[15:0]});
        add_entry(mem_req(1'b1, 4'hF, 10'd5, m1), {1'b0, 32'h0});
        add_entry(mem_req(1'b1, 4'hF, 10'd200, m2), {1'b0, 32'h0});
        add_entry(mem_req(1'b0, 4'h0, 10'd200, '0), {1'b0, m2});
        add_entry(mem_req(1'b1, 4'b0101, 10'd5, m3), {1'b0, 32'h0});
        add_entry(mem_req(1'b0, 4'h0, 10'd5, '0), {1'b0, merged});
        // Error cases followed by reads that show nothing changed
        add_entry(reg_req(1'b0, 6'd9, '0), {1'b1, 32'h0});
        // Address 12 matches scratch in its low bits
        add_entry(reg_req(1'b1, 6'd12, m4), {1'b1, 32'h0});
        add_entry(reg_req(1'b0, 6'd4, '0), {1'b0, scr});
        // Address 261 wraps onto word 5 in the low bits
        add_entry(mem_req(1'b1, 4'hF, 10'd261, m4), {1'b1, 32'h0});
        add_entry(mem_req(1'b0, 4'h0, 10'd5, '0), {1'b0, merged});
        add_entry(reg_req(1'b1, 6'd0, m4), {1'b1, 32'h0});
        add_entry(reg_req(1'b0, 6'd0, '0), {1'b0, 32'h2050_5245});

        cycle_limit = 16 + 12 * req_tbl.size() + 50;
        cycle_cnt   = 0;
        srst        = 1'b1;
        i_req       = 1'b0;
        i_req_data  = '0;
        exp_resp    = '0;
        repeat (16) @(negedge clk);
        srst = 1'b0;
        @(negedge clk);

        // --------------------------------------------------
        // Four-phase driver
        // --------------------------------------------------
        for (int i = 0; i < req_tbl.size(); i++) begin
            exp_resp   = exp_tbl[i];
            i_req_data = req_tbl[i];
            i_req      = 1'b1;
            do @(negedge clk); while (!o_ack);
            i_req = 1'b0;
            do @(negedge clk); while (o_ack);
        end
        repeat (2) @(negedge clk);

        total_errors = chk_errors + DUT.handshake_props.fail_count;
        $display("Checks: %0d, checker errors: %0d, assertion failures: %0d",
                 checks, chk_errors, DUT.handshake_props.fail_count);
        if (total_errors == 0 && checks == req_tbl.size()) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : proxy_test_tb

//--- verif/proxy_test_properties.sv
`timescale 1ns/1ps

module proxy_test_properties (
    input logic                   clk,
    input logic                   srst,
    input logic                   i_req,
    input logic                   i_ack,
    input proxy_pkg::proxy_resp_t i_resp
);
    int fail_count = 0;

    // --------------------------------------------------
    // Four-phase handshake rules
    // --------------------------------------------------
    ack_low_in_reset: assert property (@(posedge clk) srst |=> !i_ack)
        else begin
            $error("ack high during reset");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (srst)
        (!i_req && !i_ack) |=> !i_ack)
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    resp_stable: assert property (@(posedge clk) disable iff (srst)
        i_ack |=> (!i_ack || $stable(i_resp)))
        else begin
            $error("response changed while ack was high");
            fail_count++;
        end

    ack_release: assert property (@(posedge clk) disable iff (srst)
        $fell(i_req) |=> !i_ack)
        else begin
            $error("ack did not fall one cycle after req fell");
            fail_count++;
        end

endmodule : proxy_test_properties

bind proxy_test proxy_test_properties handshake_props (
    .clk    ( clk ),
    .srst   ( srst ),
    .i_req  ( i_req ),
    .i_ack  ( o_ack ),
    .i_resp ( o_resp )
);

//--- verif/proxy_test_checker.sv
`timescale 1ns/1ps

module proxy_test_checker (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   i_req,
    input  logic                   i_ack,
    input  proxy_pkg::proxy_resp_t i_resp,
    input  proxy_pkg::proxy_resp_t i_exp,
    output int                     o_checks,
    output int                     o_errors
);
    import proxy_pkg::*;

    // Edges from request sample to ack rise
    localparam int ACK_LATENCY = 3;

    typedef enum logic [1:0] {
        PH_WAIT,
        PH_PEND,
        PH_ACKED
    } phase_e;

    phase_e phase;
    int     edge_idx;
    logic   req_low_seen;

    // --------------------------------------------------
    // Handshake tracking on values sampled before the DUT updates
    // --------------------------------------------------
    always @(posedge clk) begin
        if (srst) begin
            phase        = PH_WAIT;
            edge_idx     = 0;
            req_low_seen = 1'b0;
            o_checks     = 0;
            o_errors     = 0;
        end else begin
            case (phase)
                PH_WAIT: begin
                    // This edge is N
                    if (i_req && !i_ack) begin
                        phase    = PH_PEND;
                        edge_idx = 0;
                    end
                end
                PH_PEND: begin
                    edge_idx++;
                    if (i_ack) begin
                        // Ack rose at the previous edge
                        if (edge_idx - 1 != ACK_LATENCY) begin
                            o_errors++;
                            $display("Ack latency was %0d edges instead of %0d (time %0t)",
                                     edge_idx - 1, ACK_LATENCY, $time);
                        end
                        o_checks++;
                        if (i_resp !== i_exp) begin
                            o_errors++;
                            $display("CHECK FAILED at %0t: resp %0b/%08h, expected %0b/%08h",
                                     $time, i_resp.err, i_resp.rdata, i_exp.err, i_exp.rdata);
                        end
                        phase        = PH_ACKED;
                        req_low_seen = 1'b0;
                    end
                end
                default: begin
                    if (!i_ack) begin
                        phase = PH_WAIT;
                    end else if (req_low_seen) begin
                        o_errors++;
                        $display("Ack was still high one cycle after req dropped (time %0t)", $time);
                    end
                    req_low_seen = !i_req;
                end
            endcase
        end
    end

endmodule : proxy_test_checker

//--- hdl/proxy_test.sv
`timescale 1ns/1ps

module proxy_test (
    input  logic                   clk,
    input  logic                   srst,
    input  logic                   i_req,
    input  proxy_pkg::proxy_req_t  i_req_data,
    output logic                   o_ack,
    output proxy_pkg::proxy_resp_t o_resp
);
    import proxy_pkg::*;

    exec_cmd_t           cmd;
    logic [DATA_WID-1:0] reg_rdata;
    logic                reg_done;
    logic [DATA_WID-1:0] mem_rdata;
    logic                mem_done;
    logic                idle;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    proxy_cmd_decode proxy_cmd_decode (
        .clk,
        .srst,
        .i_req      ( i_req ),
        .i_req_data ( i_req_data ),
        .i_idle     ( idle ),
        .o_cmd      ( cmd )
    );

    // --------------------------------------------------
    // Execute stage with register block and RAM side by side
    // --------------------------------------------------
    proxy_reg_blk proxy_reg_blk (
        .clk,
        .srst,
        .i_cmd   ( cmd ),
        .o_rdata ( reg_rdata ),
        .o_done  ( reg_done )
    );

    proxy_mem_exec proxy_mem_exec (
        .clk,
        .srst,
        .i_cmd   ( cmd ),
        .o_rdata ( mem_rdata ),
        .o_done  ( mem_done )
    );

    // --------------------------------------------------
    // Result and handshake
    // --------------------------------------------------
    proxy_resp_gen proxy_resp_gen (
        .clk,
        .srst,
        .i_req       ( i_req ),
        .i_cmd_err   ( cmd.err ),
        .i_reg_rdata ( reg_rdata ),
        .i_reg_done  ( reg_done ),
        .i_mem_rdata ( mem_rdata ),
        .i_mem_done  ( mem_done ),
        .o_resp      ( o_resp ),
        .o_ack       ( o_ack ),
        .o_idle      ( idle )
    );

endmodule : proxy_test

//--- hdl/proxy_resp_gen.sv
`timescale 1ns/1ps

module proxy_resp_gen (
    input  logic                           clk,
    input  logic                           srst,
    input  logic                           i_req,
    input  logic                           i_cmd_err,
    input  logic [proxy_pkg::DATA_WID-1:0] i_reg_rdata,
    input  logic                           i_reg_done,
    input  logic [proxy_pkg::DATA_WID-1:0] i_mem_rdata,
    input  logic                           i_mem_done,
    output proxy_pkg::proxy_resp_t         o_resp,
    output logic                           o_ack,
    output logic                           o_idle
);
    import proxy_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK,
        ST_RELEASE
    } state_e;

    state_e      state;
    logic        done;
    proxy_resp_t resp_nxt;

    assign done   = i_reg_done || i_mem_done;
    assign o_idle = (state == ST_IDLE);

    // Error response carries no data
    always_comb begin
        resp_nxt.err   = i_cmd_err;
        resp_nxt.rdata = i_cmd_err  ? '0 :
                         i_reg_done ? i_reg_rdata : i_mem_rdata;
    end

    // --------------------------------------------------
    // Four-phase handshake FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_IDLE;
            o_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req) state <= ST_BUSY;
                end
                ST_BUSY: begin
                    if (done) begin
                        o_ack <= 1'b1;
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // Held high until the host drops req
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= ST_RELEASE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_BUSY && done) begin
            o_resp <= resp_nxt;
        end
    end

endmodule : proxy_resp_gen

//--- hdl/proxy_mem_exec.sv
`timescale 1ns/1ps

module proxy_mem_exec (
    input  logic                           clk,
    input  logic                           srst,
    input  proxy_pkg::exec_cmd_t           i_cmd,
    output logic [proxy_pkg::DATA_WID-1:0] o_rdata,
    output logic                           o_done
);
    import proxy_pkg::*;

    logic [DATA_WID-1:0] ram [MEM_DEPTH];
    logic                cmd_hit;
    logic                cmd_ok;

    assign cmd_hit = i_cmd.valid && (i_cmd.space == SPACE_MEM);
    assign cmd_ok  = cmd_hit && !i_cmd.err;

    // --------------------------------------------------
    // Single-port RAM with byte enables
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (cmd_ok && i_cmd.wr) begin
            for (int b = 0; b < BE_WID; b++) begin
                if (i_cmd.byte_en[b]) begin
                    ram[i_cmd.mem_addr][b*BYTE_BITS +: BYTE_BITS] <=
                        i_cmd.wdata[b*BYTE_BITS +: BYTE_BITS];
                end
            end
        end
    end

    // Registered read with zero for writes and errors
    always_ff @(posedge clk) begin
        if (cmd_hit) begin
            if (cmd_ok && !i_cmd.wr) begin
                o_rdata <= ram[i_cmd.mem_addr];
            end else begin
                o_rdata <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            o_done <= 1'b0;
        end else begin
            o_done <= cmd_hit;
        end
    end

endmodule : proxy_mem_exec

//--- hdl/proxy_reg_blk.sv
`timescale 1ns/1ps

module proxy_reg_blk (
    input  logic                           clk,
    input  logic                           srst,
    input  proxy_pkg::exec_cmd_t           i_cmd,
    output logic [proxy_pkg::DATA_WID-1:0] o_rdata,
    output logic                           o_done
);
    import proxy_pkg::*;

    typedef struct packed {
        logic [DATA_WID/2-1:0] count;
        logic [DATA_WID/2-1:0] last_trig;
    } status_t;

    logic [DATA_WID-1:0] trigger_r;
    logic [DATA_WID-1:0] scratch_r;
    status_t             status_r;
    logic                cmd_hit;
    logic                cmd_ok;
    logic [DATA_WID-1:0] rd_word;

    assign cmd_hit = i_cmd.valid && (i_cmd.space == SPACE_REG);
    assign cmd_ok  = cmd_hit && !i_cmd.err;

    // --------------------------------------------------
    // Writable registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            trigger_r <= '0;
            scratch_r <= '0;
            status_r  <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= cmd_hit;
            if (cmd_ok && i_cmd.wr) begin
                case (i_cmd.reg_addr)
                    REG_TRIGGER: begin
                        trigger_r          <= i_cmd.wdata;
                        // Status tracks every trigger write
                        status_r.last_trig <= i_cmd.wdata[DATA_WID/2-1:0];
                        status_r.count     <= status_r.count + 1'b1;
                    end
                    REG_SCRATCH: begin
                        scratch_r <= i_cmd.wdata;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_comb begin
        case (i_cmd.reg_addr)
            REG_PRE:     rd_word = PRE_ID;
            REG_POST:    rd_word = POST_ID;
            REG_TRIGGER: rd_word = trigger_r;
            REG_STATUS:  rd_word = status_r;
            REG_SCRATCH: rd_word = scratch_r;
            default:     rd_word = '0;
        endcase
    end

    // Zero for writes and for errored commands
    always_ff @(posedge clk) begin
        if (cmd_hit) begin
            o_rdata <= (cmd_ok && !i_cmd.wr) ? rd_word : '0;
        end
    end

endmodule : proxy_reg_blk

//--- hdl/proxy_cmd_decode.sv
`timescale 1ns/1ps

module proxy_cmd_decode (
    input  logic                  clk,
    input  logic                  srst,
    input  logic                  i_req,
    input  proxy_pkg::proxy_req_t i_req_data,
    input  logic                  i_idle,
    output proxy_pkg::exec_cmd_t  o_cmd
);
    import proxy_pkg::*;

    proxy_req_t req_r;
    logic       accept;
    logic       start_r;
    logic       valid_r;
    exec_cmd_t  cmd_nxt;
    exec_cmd_t  cmd_r;

    // --------------------------------------------------
    // Request capture
    // --------------------------------------------------
    // New request only while the response side sits idle
    assign accept = i_req && i_idle;

    always_ff @(posedge clk) begin
        if (srst) begin
            start_r <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            start_r <= accept;
            valid_r <= start_r;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= i_req_data;
        end
    end

    // --------------------------------------------------
    // Field split and address checks
    // --------------------------------------------------
    always_comb begin
        cmd_nxt       = '0;
        cmd_nxt.space = req_r.space;
        cmd_nxt.wr    = req_r.wr;
        cmd_nxt.wdata = req_r.wdata;
        if (req_r.space == SPACE_REG) begin
            cmd_nxt.reg_addr = req_r.op.reg_op.addr;
            if (req_r.op.reg_op.addr > REG_SCRATCH) begin
                cmd_nxt.err = 1'b1;
            end else if (req_r.wr &&
                         (req_r.op.reg_op.addr inside {REG_PRE, REG_POST, REG_STATUS})) begin
                // Read-only registers
                cmd_nxt.err = 1'b1;
            end
        end else begin
            cmd_nxt.byte_en  = req_r.op.mem_op.byte_en;
            cmd_nxt.mem_addr = req_r.op.mem_op.addr[MEM_IDX_WID-1:0];
            cmd_nxt.err      = (req_r.op.mem_op.addr >= MEM_DEPTH);
        end
    end

    // Payload held until the next request
    always_ff @(posedge clk) begin
        if (start_r) begin
            cmd_r <= cmd_nxt;
        end
    end

    always_comb begin
        o_cmd       = cmd_r;
        o_cmd.valid = valid_r;
    end

endmodule : proxy_cmd_decode

//--- hdl/proxy_pkg.sv
package proxy_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int DATA_WID     = 32;
    localparam int BYTE_BITS    = 8;
    localparam int BE_WID       = DATA_WID / BYTE_BITS;
    localparam int MEM_DEPTH    = 256;
    localparam int MEM_ADDR_WID = 10;
    localparam int MEM_IDX_WID  = $clog2(MEM_DEPTH);
    localparam int REG_ADDR_WID = 6;
    localparam int OP_WID       = 14;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam logic [REG_ADDR_WID-1:0] REG_PRE     = 6'd0;
    localparam logic [REG_ADDR_WID-1:0] REG_POST    = 6'd1;
    localparam logic [REG_ADDR_WID-1:0] REG_TRIGGER = 6'd2;
    localparam logic [REG_ADDR_WID-1:0] REG_STATUS  = 6'd3;
    localparam logic [REG_ADDR_WID-1:0] REG_SCRATCH = 6'd4;

    // ASCII " PRE" and "POST"
    localparam logic [DATA_WID-1:0] PRE_ID  = 32'h2050_5245;
    localparam logic [DATA_WID-1:0] POST_ID = 32'h504F_5354;

    // --------------------------------------------------
    // Request and response words
    // --------------------------------------------------
    typedef enum logic {
        SPACE_REG = 1'b0,
        SPACE_MEM = 1'b1
    } space_e;

    typedef struct packed {
        logic [OP_WID-REG_ADDR_WID-1:0] rsvd;
        logic [REG_ADDR_WID-1:0]        addr;
    } reg_op_t;

    typedef struct packed {
        logic [BE_WID-1:0]       byte_en;
        logic [MEM_ADDR_WID-1:0] addr;
    } mem_op_t;

    // Meaning of the op field depends on the space bit
    typedef union packed {
        reg_op_t reg_op;
        mem_op_t mem_op;
    } proxy_op_u;

    typedef struct packed {
        space_e              space;
        logic                wr;
        proxy_op_u           op;
        logic [DATA_WID-1:0] wdata;
    } proxy_req_t;

    // Decoded command from decode to execute
    typedef struct packed {
        logic                    valid;
        space_e                  space;
        logic                    wr;
        logic                    err;
        logic [REG_ADDR_WID-1:0] reg_addr;
        logic [MEM_IDX_WID-1:0]  mem_addr;
        logic [BE_WID-1:0]       byte_en;
        logic [DATA_WID-1:0]     wdata;
    } exec_cmd_t;

    typedef struct packed {
        logic                err;
        logic [DATA_WID-1:0] rdata;
    } proxy_resp_t;

endpackage : proxy_pkg
